// ==== noc_macros.svh ====
// sizing constants for the two-port router slice
// flit width, buffer depth, port count, routing bit
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// payload bits per flit, excluding the last flag
`define NOC_FLIT_WIDTH 32

// flits per input buffer, also the longest legal packet
`define NOC_BUF_DEPTH 8

// inputs and outputs of the router
`define NOC_PORTS 2

// header payload bit that names the output port
`define NOC_DEST_BIT 31

`endif

// ==== noc_pkg.sv ====
// shared types for the router slice
// flit struct and per-port bit vectors
`include "noc_macros.svh"

package noc_pkg;

   // one flit on any link in the router
   // last marks the end of a packet, the next flit is a header
   typedef struct packed {
      logic                       last;
      logic [`NOC_FLIT_WIDTH-1:0] data;   // header carries the destination in the top bit
   } noc_flit_t;

   // one bit per port
   // request, grant and ready vectors all use this
   typedef logic [`NOC_PORTS-1:0] port_vec_t;

endpackage

// ==== noc_buffer.sv ====
// flit buffer for one router input
// shift register with read pointer on the oldest flit
// optional full-packet hold with packet size report
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_buffer #(
   parameter int DEPTH      = `NOC_BUF_DEPTH,
   parameter bit FULLPACKET = 1'b0
) (
   input  logic                         clk,
   input  logic                         rst,
   input  noc_pkg::noc_flit_t           in_flit,
   input  logic                         in_valid,
   output logic                         in_ready,
   output noc_pkg::noc_flit_t           out_flit,
   output logic                         out_valid,
   input  logic                         out_ready,
   output logic [$clog2(DEPTH+1)-1:0]   packet_size
);

   localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int SIZE_W = $clog2(DEPTH+1);   // sizes run 1..DEPTH

   noc_pkg::noc_flit_t data [DEPTH];   // index 0 is the newest flit
   logic [PTR_W-1:0]   rp;             // read pointer, oldest flit
   logic               filled;         // at least one flit stored
   logic               in_fire;
   logic               out_fire;

   // full only when the pointer sits on the top slot with data in it
   assign in_ready = !filled || (rp != PTR_W'(DEPTH-1));
   assign in_fire  = in_valid && in_ready;
   assign out_fire = out_valid && out_ready;
   assign out_flit = data[rp];

   always_ff @(posedge clk) begin
      if (rst) begin
         filled <= 1'b0;
      end else if (in_fire) begin
         filled <= 1'b1;
      end else if (out_fire && rp == '0) begin
         filled <= 1'b0;   // last stored flit left
      end
   end

   // push and pop together leave rp alone
   always_ff @(posedge clk) begin
      if (rst) begin
         rp <= '0;
      end else if (in_fire && !out_fire && filled) begin
         rp <= rp + 1'b1;
      end else if (out_fire && !in_fire && rp != '0) begin
         rp <= rp - 1'b1;
      end
   end

   // new flits enter at the bottom, older ones move up
   always_ff @(posedge clk) begin
      if (in_fire) begin
         data[0] <= in_flit;
         for (int i = 1; i < DEPTH; i++) begin
            data[i] <= data[i-1];
         end
      end
   end

   generate
      if (FULLPACKET) begin : g_full
         logic [DEPTH-1:0] last_buf;   // shadow copy of the stored last bits
         logic [DEPTH-1:0] last_win;   // stored flits only, oldest at msb

         // leading one from the top gives the oldest packet's end
         function automatic logic [SIZE_W-1:0] size_of(input logic [DEPTH-1:0] win);
            logic [SIZE_W-1:0] size;
            size = '0;
            for (int i = 0; i < DEPTH; i++) begin
               if (win[i]) begin
                  size = SIZE_W'(DEPTH - i);   // higher hits overwrite lower
               end
            end
            return size;
         endfunction

         always_ff @(posedge clk) begin
            if (rst) begin
               last_buf <= '0;
            end else if (in_fire) begin
               last_buf <= (last_buf << 1) | DEPTH'(in_flit.last);
            end
         end

         // popped entries above rp fall off the top
         assign last_win    = last_buf << (DEPTH - 1 - int'(rp));
         assign out_valid   = filled && |last_win;   // hold until a last flit is in
         assign packet_size = out_valid ? size_of(last_win) : '0;
      end else begin : g_plain
         assign out_valid   = filled;
         // no packet boundaries tracked here, report fill level
         assign packet_size = filled ? SIZE_W'(rp) + 1'b1 : '0;
      end
   endgenerate

endmodule

// ==== noc_input_port.sv ====
// router input port
// full-packet buffer plus destination decode
// request stays on one output for the whole packet
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_input_port (
   input  logic               clk,
   input  logic               rst,
   input  noc_pkg::noc_flit_t in_flit,
   input  logic               in_valid,
   output logic               in_ready,
   output noc_pkg::port_vec_t req,
   output noc_pkg::noc_flit_t buf_flit,
   input  logic               pop
);

   logic buf_valid;   // buffer offers a flit of a complete packet
   logic pop_fire;
   logic mid_pkt;     // header already gone, body flits follow
   logic dest_q;      // destination of the packet in flight
   logic dest;

   noc_buffer #(
      .DEPTH      (`NOC_BUF_DEPTH),
      .FULLPACKET (1'b1)
   ) buffer_inst (
      .clk         (clk),
      .rst         (rst),
      .in_flit     (in_flit),
      .in_valid    (in_valid),
      .in_ready    (in_ready),
      .out_flit    (buf_flit),
      .out_valid   (buf_valid),
      .out_ready   (pop),
      .packet_size ()
   );

   assign pop_fire = buf_valid && pop;

   // header routes itself, body uses the stored bit
   assign dest = mid_pkt ? dest_q : buf_flit.data[`NOC_DEST_BIT];

   always_comb begin
      req = '0;
      if (buf_valid) begin
         req[dest] = 1'b1;   // one-hot toward the chosen output
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mid_pkt <= 1'b0;
      end else if (pop_fire) begin
         mid_pkt <= !buf_flit.last;   // single-flit packets never set it
      end
   end

   always_ff @(posedge clk) begin
      if (pop_fire && !mid_pkt) begin
         dest_q <= buf_flit.data[`NOC_DEST_BIT];   // capture on the header
      end
   end

endmodule

// ==== noc_output_port.sv ====
// router output port
// round-robin arbiter locked per packet, plus flit mux
`timescale 1ns/1ps

module noc_output_port #(
   parameter int PORT_ID = 0   // request bit this output answers to
) (
   input  logic               clk,
   input  logic               rst,
   input  noc_pkg::port_vec_t req0,
   input  noc_pkg::port_vec_t req1,
   input  noc_pkg::noc_flit_t flit0,
   input  noc_pkg::noc_flit_t flit1,
   output noc_pkg::port_vec_t grant,
   output noc_pkg::noc_flit_t out_flit,
   output logic               out_valid,
   input  logic               out_ready
);

   noc_pkg::port_vec_t want;    // inputs asking for this output
   noc_pkg::port_vec_t owner;   // locked input, one-hot, zero when idle
   noc_pkg::port_vec_t pick;    // winner if arbitrating now
   noc_pkg::port_vec_t active;
   logic               prio;    // input favoured at the next arbitration
   logic               out_fire;

   assign want = {req1[PORT_ID], req0[PORT_ID]};

   // favoured input first, otherwise the other one
   always_comb begin
      pick = '0;
      if (want[prio]) begin
         pick[prio] = 1'b1;
      end else if (want[!prio]) begin
         pick[!prio] = 1'b1;
      end
   end

   assign active    = owner & want;   // owner still offering a flit
   assign out_valid = |active;
   assign out_flit  = owner[1] ? flit1 : flit0;
   assign out_fire  = out_valid && out_ready;

   // grant doubles as the pop of the owning input
   assign grant = out_ready ? active : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         owner <= '0;
         prio  <= 1'b0;
      end else if (owner == '0) begin
         owner <= pick;   // lock for the whole packet
      end else if (out_fire && out_flit.last) begin
         owner <= '0;
         prio  <= owner[0];   // other input goes first next time
      end
   end

endmodule

// ==== noc_router.sv ====
// two-port router slice top
// input ports feed both output ports, grants come back as pops
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_router (
   input  logic               clk,
   input  logic               rst,
   input  noc_pkg::noc_flit_t in_flit [`NOC_PORTS],
   input  noc_pkg::port_vec_t in_valid,
   output noc_pkg::port_vec_t in_ready,
   output noc_pkg::noc_flit_t out_flit [`NOC_PORTS],
   output noc_pkg::port_vec_t out_valid,
   input  noc_pkg::port_vec_t out_ready
);

   noc_pkg::port_vec_t req [`NOC_PORTS];        // per input
   noc_pkg::noc_flit_t buf_flit [`NOC_PORTS];   // per input, head of buffer
   noc_pkg::port_vec_t grant [`NOC_PORTS];      // per output, one bit per input
   noc_pkg::port_vec_t pop;                     // per input

   generate
      for (genvar i = 0; i < `NOC_PORTS; i++) begin : g_in
         // an input is served by at most one output at a time
         assign pop[i] = grant[0][i] | grant[1][i];

         noc_input_port in_port_inst (
            .clk      (clk),
            .rst      (rst),
            .in_flit  (in_flit[i]),
            .in_valid (in_valid[i]),
            .in_ready (in_ready[i]),
            .req      (req[i]),
            .buf_flit (buf_flit[i]),
            .pop      (pop[i])
         );
      end

      for (genvar j = 0; j < `NOC_PORTS; j++) begin : g_out
         noc_output_port #(
            .PORT_ID (j)
         ) out_port_inst (
            .clk       (clk),
            .rst       (rst),
            .req0      (req[0]),
            .req1      (req[1]),
            .flit0     (buf_flit[0]),
            .flit1     (buf_flit[1]),
            .grant     (grant[j]),
            .out_flit  (out_flit[j]),
            .out_valid (out_valid[j]),
            .out_ready (out_ready[j])
         );
      end
   endgenerate

endmodule

// ==== tb_noc_router.sv ====
// testbench for the two-port router slice
// table driven packets, per route scoreboard, hold and fairness checks
`timescale 1ns/1ps
`include "noc_macros.svh"

module tb_noc_router;

   localparam int NUM_GRP  = 4;
   localparam int FAIR_GRP = 2;                       // both inputs to output 0
   localparam bit [NUM_GRP-1:0] RND_GRPS = 4'b1010;   // random ready and gaps

   // one table row per packet
   typedef struct packed {
      logic [3:0]  grp;    // test group
      logic        src;    // input port
      logic        dst;    // output port, goes into header bit 31
      logic [3:0]  len;    // 1..8 flits
      logic [31:0] base;   // flit k carries base + k
   } pkt_t;

   logic               clk = 1'b0;   // low from the start, no edge at time 0
   logic               rst;
   noc_pkg::noc_flit_t in_flit [`NOC_PORTS];
   noc_pkg::port_vec_t in_valid;
   noc_pkg::port_vec_t in_ready;
   noc_pkg::noc_flit_t out_flit [`NOC_PORTS];
   noc_pkg::port_vec_t out_valid;
   noc_pkg::port_vec_t out_ready;

   pkt_t               pkt_tab [$];
   int                 pkt_cnt;
   int                 total_flits;
   int                 cycle = 0;
   logic               rnd_ready;
   logic               gaps;
   logic               fair_on;

   // scoreboard, indexed by source * ports + destination
   noc_pkg::noc_flit_t exp_q [`NOC_PORTS*`NOC_PORTS][$];
   int                 done_q [`NOC_PORTS*`NOC_PORTS][$];   // cycle of each last accept
   int                 occ [`NOC_PORTS];       // flits held per input buffer
   int                 in_dst [`NOC_PORTS];
   logic               in_mid [`NOC_PORTS];
   int                 out_src [`NOC_PORTS];
   logic               out_mid [`NOC_PORTS];
   int                 fair_prev;
   logic               first_done;

   noc_router noc_router_inst (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial begin
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   task automatic abort_run();
      $display("Testbench failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] want);
      if (got !== want) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
         abort_run();
      end
   endtask

   function automatic int qidx(input int s, input int d);
      return s * `NOC_PORTS + d;
   endfunction

   // flit k of a packet, header routed by bit 31
   function automatic noc_pkg::noc_flit_t flit_word(input pkt_t p, input int idx);
      noc_pkg::noc_flit_t f;
      f.data = p.base + 32'(idx);
      if (idx == 0) begin
         f.data[`NOC_DEST_BIT] = p.dst;
      end
      f.last = (idx == int'(p.len) - 1);
      return f;
   endfunction

   // flip sets bit 31 of the body words, so body flits look misrouted
   task automatic add_pkt(input int grp, input int src, input int dst, input int len,
                          input int flip);
      pkt_t p;
      p.grp  = 4'(grp);
      p.src  = 1'(src);
      p.dst  = 1'(dst);
      p.len  = 4'(len);
      p.base = {1'(flip), 15'(pkt_cnt), 16'h0};   // unique per packet
      pkt_tab.push_back(p);
      pkt_cnt++;
      total_flits += len;
   endtask

   task automatic build_table();
      // group 0, every route once, out_ready held high
      add_pkt(0, 0, 0, 1, 0);
      add_pkt(0, 0, 1, 3, 1);
      add_pkt(0, 1, 1, 2, 0);
      add_pkt(0, 1, 0, 4, 1);
      add_pkt(0, 0, 0, 8, 1);
      add_pkt(0, 1, 1, 5, 0);
      // group 1, mixed routes and lengths
      for (int n = 0; n < 16; n++) begin
         add_pkt(1, n % 2, $urandom_range(1, 0), $urandom_range(8, 1), $urandom_range(1, 0));
      end
      // group 2, equal packets from both inputs into output 0
      for (int n = 0; n < 8; n++) begin
         add_pkt(2, n % 2, 0, 3, n % 2);
      end
      // group 3, long packets under back-pressure
      for (int n = 0; n < 12; n++) begin
         add_pkt(3, n % 2, $urandom_range(1, 0), $urandom_range(8, 6), $urandom_range(1, 0));
      end
   endtask

   task automatic send_packet(input int port, input pkt_t p);
      logic taken;
      for (int idx = 0; idx < int'(p.len); idx++) begin
         if (gaps) begin
            repeat ($urandom_range(2, 0)) begin   // idle gap, also mid packet
               @(posedge clk);
               #2;
            end
         end
         in_flit[port]  = flit_word(p, idx);
         in_valid[port] = 1'b1;
         do begin
            @(negedge clk);
            taken = in_ready[port];   // stable until the edge
            @(posedge clk);
            #2;
         end while (!taken);
         in_valid[port] = 1'b0;
      end
   endtask

   task automatic drive_port(input int port, input int grp);
      for (int k = 0; k < pkt_tab.size(); k++) begin
         if (int'(pkt_tab[k].grp) == grp && int'(pkt_tab[k].src) == port) begin
            send_packet(port, pkt_tab[k]);
         end
      end
   endtask

   function automatic int pending();
      int n;
      n = 0;
      for (int q = 0; q < `NOC_PORTS*`NOC_PORTS; q++) begin
         n += exp_q[q].size();
      end
      return n;
   endfunction

   // which input's packet a header on output j belongs to
   function automatic int find_src(input int j, input noc_pkg::noc_flit_t f);
      for (int s = 0; s < `NOC_PORTS; s++) begin
         if (exp_q[qidx(s, j)].size() > 0 && exp_q[qidx(s, j)][0] === f) begin
            return s;
         end
      end
      return -1;
   endfunction

   task automatic check_idle();
      check_val("out_valid", 64'(out_valid), 64'(0));
      check_val("in_ready", 64'(in_ready), 64'(2'b11));
   endtask

   // monitor, sampled mid cycle where all signals are settled
   always @(negedge clk) begin : monitor
      int s;
      int q;
      noc_pkg::noc_flit_t want_flit;
      if (!fair_on) fair_prev = -1;
      if (rst) begin
         check_idle();
         first_done = 1'b0;
         for (int i = 0; i < `NOC_PORTS; i++) begin
            occ[i]     = 0;
            in_mid[i]  = 1'b0;
            out_mid[i] = 1'b0;
         end
      end else begin
         if (!first_done) begin
            check_idle();
            first_done = 1'b1;
         end
         // input side, ready low only with a full buffer
         for (int i = 0; i < `NOC_PORTS; i++) begin
            check_val($sformatf("in_ready[%0d]", i), 64'(in_ready[i]),
                      64'(occ[i] < `NOC_BUF_DEPTH));
            if (in_valid[i] && in_ready[i]) begin
               if (!in_mid[i]) in_dst[i] = int'(in_flit[i].data[`NOC_DEST_BIT]);
               exp_q[qidx(i, in_dst[i])].push_back(in_flit[i]);
               if (in_flit[i].last) done_q[qidx(i, in_dst[i])].push_back(cycle);
               in_mid[i] = !in_flit[i].last;
               occ[i]++;
            end
         end
         // output side
         for (int j = 0; j < `NOC_PORTS; j++) begin
            if (out_valid[j]) begin
               if (!out_mid[j]) begin
                  s = find_src(j, out_flit[j]);
                  if (s < 0) begin
                     $display("output %0d offers header 0x%0h that heads no pending packet",
                              j, out_flit[j]);
                     abort_run();
                  end else if (done_q[qidx(s, j)].size() == 0 ||
                               done_q[qidx(s, j)][0] >= cycle) begin
                     $display("header on output %0d shown before its last flit was accepted",
                              j);
                     abort_run();
                  end else begin
                     out_src[j] = s;
                  end
               end
               if (out_ready[j]) begin
                  q = qidx(out_src[j], j);
                  if (exp_q[q].size() == 0) begin
                     $display("output %0d sent a flit that no input sent to it", j);
                     abort_run();
                  end else begin
                     want_flit = exp_q[q].pop_front();
                     check_val($sformatf("out_flit[%0d].data", j), 64'(out_flit[j].data),
                               64'(want_flit.data));
                     check_val($sformatf("out_flit[%0d].last", j), 64'(out_flit[j].last),
                               64'(want_flit.last));
                     if (!out_mid[j]) begin
                        void'(done_q[q].pop_front());
                        if (fair_on && j == 0) begin   // sources take turns
                           if (fair_prev >= 0) begin
                              check_val("output 0 packet source", 64'(out_src[j]),
                                        64'(1 - fair_prev));
                           end
                           fair_prev = out_src[j];
                        end
                     end
                     occ[out_src[j]]--;
                     out_mid[j] = !out_flit[j].last;
                  end
               end
            end
         end
      end
   end

   initial begin : ready_gen
      out_ready = 2'b00;
      forever begin
         @(posedge clk);
         #2;
         out_ready = rnd_ready ? 2'($urandom_range(3, 0)) : 2'b11;
      end
   end

   // limit scales with the table length
   initial begin : watchdog
      @(negedge rst);
      repeat (total_flits * 40 + 1000) @(posedge clk);
      $display("timeout, packets still in flight after %0d cycles", cycle);
      abort_run();
   end

   initial begin
      void'($urandom(56661));
      rst         = 1'b1;
      in_valid    = '0;
      in_flit[0]  = '0;
      in_flit[1]  = '0;
      rnd_ready   = 1'b0;
      gaps        = 1'b0;
      fair_on     = 1'b0;
      pkt_cnt     = 0;
      total_flits = 0;
      build_table();
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      for (int g = 0; g < NUM_GRP; g++) begin
         rnd_ready = RND_GRPS[g];
         gaps      = RND_GRPS[g];
         fair_on   = (g == FAIR_GRP);
         fork
            drive_port(0, g);
            drive_port(1, g);
         join
         while (pending() != 0) begin   // drain before the next group
            @(posedge clk);
            #2;
         end
      end
      fair_on = 1'b0;
      // router idle again, buffers empty and outputs quiet
      check_idle();
      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+.
noc_pkg.sv
noc_buffer.sv
noc_input_port.sv
noc_output_port.sv
noc_router.sv
tb_noc_router.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the router testbench with Verilator, run it, then search the log
rm -rf obj_dir sim.log
verilator --binary --timing -f filelist.f --top-module tb_noc_router -o sim_tb &&
   ./obj_dir/sim_tb > sim.log 2>&1
grep -q "Testbench passed" sim.log && echo "simulation ok" || {
   echo "simulation did not pass, see sim.log"
   exit 1
}
exit 0
